/* common/mul_defines.svh */
// Operand, product and pipeline constants for the multiplier, included by files that size ports
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Operand and product widths
`define MUL_WIDTH 32
`define MUL_PROD_WIDTH 64

// Radix-4 recoding gives one partial product per multiplier bit pair
`define MUL_PP_COUNT 16

// Edges from the accepting edge to the product edge
`define MUL_LATENCY 3

`endif

/* common/mul_pkg.sv */
// Shared request, conditioning and carry-save types for the multiplier, imported by its modules
`default_nettype none

`include "mul_defines.svh"

package mul_pkg;

    // Bit 1 marks the multiplicand signed, bit 0 the multiplier
    typedef enum logic [1:0] {
        MODE_UU = 2'b00,
        MODE_US = 2'b01,
        MODE_SU = 2'b10,
        MODE_SS = 2'b11
    } sign_mode_t;

    typedef struct packed {
        logic [`MUL_WIDTH-1:0] multiplicand;
        logic [`MUL_WIDTH-1:0] multiplier;
        sign_mode_t            mode;
    } mul_req_t;

    typedef struct packed {
        logic [`MUL_WIDTH-1:0] mcand_mag;
        logic [`MUL_WIDTH-1:0] mplier_mag;
        logic                  negate;
        logic                  add_high;
    } mul_prep_t;

    // Redundant result of the reduction tree
    typedef struct packed {
        logic [`MUL_PROD_WIDTH-1:0] sum;
        logic [`MUL_PROD_WIDTH-1:0] carry;
    } csa_pair_t;

    typedef enum logic {ST_IDLE, ST_BUSY} ctl_state_t;

endpackage

`default_nettype wire

/* booth/carry_save_adder.sv */
// Generic 3:2 compressor, the building block of the Wallace tree
`timescale 1ns/10ps
`default_nettype none

module carry_save_adder #(
    parameter int WIDTH = 64
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic [WIDTH-1:0] z,
    output logic [WIDTH-1:0] sum,
    output logic [WIDTH-1:0] carry
);
    logic [WIDTH-1:0] majority;

    assign sum      = x ^ y ^ z;
    assign majority = (x & y) | (y & z) | (x & z);
    // Top carry drops out, arithmetic is modulo 2^WIDTH
    assign carry    = {majority[WIDTH-2:0], 1'b0};

endmodule

`default_nettype wire

/* design/mul_control.sv */
// Sequencer for the multiplier: accepts start when idle, times the product load and finished
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module mul_control (
    input  logic CLK,
    input  logic nRST,
    input  logic start,
    output logic capture,
    output logic product_load,
    output logic finished
);
    import mul_pkg::*;

    ctl_state_t state, next_state;
    logic [1:0] stage;
    logic       last_stage;

    assign capture      = start && (state == ST_IDLE);
    assign last_stage   = (stage == 2'(`MUL_LATENCY - 1));
    assign product_load = (state == ST_BUSY) && last_stage;

    always_comb begin
        next_state = state;
        if (state == ST_IDLE && start) begin
            next_state = ST_BUSY;
        end else if (state == ST_BUSY && last_stage) begin
            next_state = ST_IDLE;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= ST_IDLE;
            stage    <= '0;
            finished <= 1'b0;
        end else begin
            state    <= next_state;
            finished <= product_load;
            // Count restarts on every accepted start
            if (capture || last_stage) begin
                stage <= '0;
            end else if (state == ST_BUSY) begin
                stage <= stage + 2'd1;
            end
        end
    end

    a_finished_single: assert property (@(posedge CLK) disable iff (!nRST)
        finished |=> !finished)
        else $error("finished held high for two cycles");

    // Load only in the busy state, a full latency after the capture
    a_load_timing: assert property (@(posedge CLK) disable iff (!nRST)
        product_load |-> (state == ST_BUSY) && $past(capture, `MUL_LATENCY))
        else $error("product_load outside its busy slot");

endmodule

`default_nettype wire

/* design/operand_prep.sv */
// Operand capture stage of the multiplier that holds the request and derives magnitudes and sign flags
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module operand_prep (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                capture,
    input  mul_pkg::mul_req_t   req,
    output mul_pkg::mul_prep_t  prep
);
    import mul_pkg::*;

    mul_req_t              req_q;
    logic                  mcand_neg;
    logic                  mplier_neg;
    logic [`MUL_WIDTH-1:0] mcand_mag;
    logic [`MUL_WIDTH-1:0] mplier_mag;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_q <= '0;
        end else if (capture) begin
            req_q <= req;
        end
    end

    // Effective signs count only in modes that treat the operand as signed
    assign mcand_neg  = (req_q.mode inside {MODE_SU, MODE_SS})
                        && req_q.multiplicand[`MUL_WIDTH-1];
    assign mplier_neg = (req_q.mode inside {MODE_US, MODE_SS})
                        && req_q.multiplier[`MUL_WIDTH-1];

    assign mcand_mag  = mcand_neg ? (~req_q.multiplicand + 1'b1) : req_q.multiplicand;
    assign mplier_mag = mplier_neg ? (~req_q.multiplier + 1'b1) : req_q.multiplier;

    assign prep.mcand_mag  = mcand_mag;
    assign prep.mplier_mag = mplier_mag;
    assign prep.negate     = mcand_neg ^ mplier_neg;
    // Booth sees a set top bit as negative weight, so the lost 2^32 x M comes back later
    assign prep.add_high   = mplier_mag[`MUL_WIDTH-1];

    // The held request must survive the whole latency window of its operation
    a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
        capture |-> !$past(capture && nRST, 1) && !$past(capture && nRST, 2)
                    && !$past(capture && nRST, 3))
        else $error("held request replaced while an operation is in flight");

endmodule

`default_nettype wire

/* booth/booth_encoder.sv */
// Radix-4 Booth recoder: builds sixteen shifted partial products and registers them each cycle
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module booth_encoder (
    input  logic                                             CLK,
    input  logic                                             nRST,
    input  logic [`MUL_WIDTH-1:0]                            mcand_mag,
    input  logic [`MUL_WIDTH-1:0]                            mplier_mag,
    output logic [`MUL_PP_COUNT-1:0][`MUL_PROD_WIDTH-1:0]    pp
);
    localparam int W = `MUL_PROD_WIDTH;

    logic [`MUL_WIDTH:0]                     mplier_ext;
    logic [W-1:0]                            m_pos1;
    logic [W-1:0]                            m_pos2;
    logic [W-1:0]                            m_neg1;
    logic [W-1:0]                            m_neg2;
    logic [`MUL_PP_COUNT-1:0][W-1:0]         pp_d;

    // Appended zero gives the first triple its low bit
    assign mplier_ext = {mplier_mag, 1'b0};

    // Multiples of M, already at full product width
    assign m_pos1 = {{(W - `MUL_WIDTH){1'b0}}, mcand_mag};
    assign m_pos2 = m_pos1 << 1;
    assign m_neg1 = ~m_pos1 + 1'b1;
    assign m_neg2 = ~m_pos2 + 1'b1;

    always_comb begin
        for (int i = 0; i < `MUL_PP_COUNT; i++) begin
            case (mplier_ext[2*i +: 3])
                3'b001, 3'b010: begin
                    pp_d[i] = m_pos1 << (2 * i);
                end
                3'b011: begin
                    pp_d[i] = m_pos2 << (2 * i);
                end
                3'b100: begin
                    pp_d[i] = m_neg2 << (2 * i);
                end
                3'b101, 3'b110: begin
                    pp_d[i] = m_neg1 << (2 * i);
                end
                default: begin
                    // 000 and 111 select zero
                    pp_d[i] = '0;
                end
            endcase
        end
    end

    // Stage register in front of the tree
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pp <= '0;
        end else begin
            pp <= pp_d;
        end
    end

endmodule

`default_nettype wire

/* booth/wallace_tree.sv */
// Wallace reduction of the partial products to a sum/carry pair, split by a register after layer 2
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module wallace_tree (
    input  logic                                             CLK,
    input  logic                                             nRST,
    input  logic [`MUL_PP_COUNT-1:0][`MUL_PROD_WIDTH-1:0]    pp,
    output mul_pkg::csa_pair_t                               tree_out
);
    localparam int W = `MUL_PROD_WIDTH;

    logic [4:0][W-1:0] l1_sum, l1_carry;
    logic [2:0][W-1:0] l2_sum, l2_carry;
    logic [7:0][W-1:0] mid_d, mid_q;
    logic [1:0][W-1:0] l3_sum, l3_carry;
    logic [1:0][W-1:0] l4_sum, l4_carry;
    logic [W-1:0]      l5_sum, l5_carry;
    logic [W-1:0]      l6_sum, l6_carry;

    // Layer 1 takes fifteen words, pp[15] waits
    for (genvar g = 0; g < 5; g++) begin : g_layer1
        carry_save_adder #(.WIDTH(W)) u_csa (
            .x     (pp[3*g]),
            .y     (pp[3*g+1]),
            .z     (pp[3*g+2]),
            .sum   (l1_sum[g]),
            .carry (l1_carry[g])
        );
    end

    // Layer 2, l1_sum[4] waits
    carry_save_adder #(.WIDTH(W)) u_csa5 (
        .x(l1_carry[0]), .y(l1_sum[0]), .z(l1_carry[1]),
        .sum(l2_sum[0]), .carry(l2_carry[0])
    );
    carry_save_adder #(.WIDTH(W)) u_csa6 (
        .x(l1_sum[1]), .y(l1_carry[2]), .z(l1_sum[2]),
        .sum(l2_sum[1]), .carry(l2_carry[1])
    );
    carry_save_adder #(.WIDTH(W)) u_csa7 (
        .x(l1_carry[3]), .y(l1_sum[3]), .z(l1_carry[4]),
        .sum(l2_sum[2]), .carry(l2_carry[2])
    );

    // Every live word crosses the mid register, leftovers included
    assign mid_d = {pp[15], l1_sum[4], l2_carry[2], l2_sum[2],
                    l2_carry[1], l2_sum[1], l2_carry[0], l2_sum[0]};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mid_q <= '0;
        end else begin
            mid_q <= mid_d;
        end
    end

    // Layer 3, mid_q[6] and mid_q[7] wait
    carry_save_adder #(.WIDTH(W)) u_csa8 (
        .x(mid_q[0]), .y(mid_q[1]), .z(mid_q[2]),
        .sum(l3_sum[0]), .carry(l3_carry[0])
    );
    carry_save_adder #(.WIDTH(W)) u_csa9 (
        .x(mid_q[3]), .y(mid_q[4]), .z(mid_q[5]),
        .sum(l3_sum[1]), .carry(l3_carry[1])
    );

    // Layer 4
    carry_save_adder #(.WIDTH(W)) u_csa10 (
        .x(l3_sum[0]), .y(l3_carry[0]), .z(l3_sum[1]),
        .sum(l4_sum[0]), .carry(l4_carry[0])
    );
    carry_save_adder #(.WIDTH(W)) u_csa11 (
        .x(l3_carry[1]), .y(mid_q[6]), .z(mid_q[7]),
        .sum(l4_sum[1]), .carry(l4_carry[1])
    );

    // Layer 5, l4_carry[1] waits
    carry_save_adder #(.WIDTH(W)) u_csa12 (
        .x(l4_sum[0]), .y(l4_carry[0]), .z(l4_sum[1]),
        .sum(l5_sum), .carry(l5_carry)
    );

    // Layer 6
    carry_save_adder #(.WIDTH(W)) u_csa13 (
        .x(l5_sum), .y(l5_carry), .z(l4_carry[1]),
        .sum(l6_sum), .carry(l6_carry)
    );

    assign tree_out.sum   = l6_sum;
    assign tree_out.carry = l6_carry;

endmodule

`default_nettype wire

/* design/product_adder.sv */
// Final stage of the multiplier: resolves the carry-save pair, applies sign fixes, holds the product
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module product_adder (
    input  logic                        CLK,
    input  logic                        nRST,
    input  mul_pkg::csa_pair_t          tree_out,
    input  mul_pkg::mul_prep_t          prep,
    input  logic                        product_load,
    output logic [`MUL_PROD_WIDTH-1:0]  product
);
    logic [`MUL_PROD_WIDTH-1:0] raw_sum;
    logic [`MUL_PROD_WIDTH-1:0] high_term;
    logic [`MUL_PROD_WIDTH-1:0] corrected;
    logic [`MUL_PROD_WIDTH-1:0] result;

    // Carry-propagate add of the redundant pair
    assign raw_sum = tree_out.sum + tree_out.carry;

    // M x 2^32 restores the weight Booth took from the top multiplier bit
    assign high_term = prep.add_high ? {prep.mcand_mag, {`MUL_WIDTH{1'b0}}} : '0;
    assign corrected = raw_sum + high_term;

    // Back to a signed product
    assign result = prep.negate ? (~corrected + 1'b1) : corrected;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            product <= '0;
        end else if (product_load) begin
            product <= result;
        end
    end

endmodule

`default_nettype wire

/* design/pp_mul_top.sv */
// Top level of the pipelined multiplier: control plus the four datapath stages
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module mul_pp_top (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        start,
    input  mul_pkg::mul_req_t           req,
    output logic [`MUL_PROD_WIDTH-1:0]  product,
    output logic                        finished
);
    import mul_pkg::*;

    logic                                           capture;
    logic                                           product_load;
    mul_prep_t                                      prep;
    logic [`MUL_PP_COUNT-1:0][`MUL_PROD_WIDTH-1:0]  pp;
    csa_pair_t                                      tree_out;

    mul_control u_control (
        .CLK          (CLK),
        .nRST         (nRST),
        .start        (start),
        .capture      (capture),
        .product_load (product_load),
        .finished     (finished)
    );

    operand_prep u_prep (
        .CLK     (CLK),
        .nRST    (nRST),
        .capture (capture),
        .req     (req),
        .prep    (prep)
    );

    booth_encoder u_booth (
        .CLK        (CLK),
        .nRST       (nRST),
        .mcand_mag  (prep.mcand_mag),
        .mplier_mag (prep.mplier_mag),
        .pp         (pp)
    );

    wallace_tree u_tree (.CLK(CLK), .nRST(nRST), .pp(pp), .tree_out(tree_out));

    product_adder u_adder (
        .CLK          (CLK),
        .nRST         (nRST),
        .tree_out     (tree_out),
        .prep         (prep),
        .product_load (product_load),
        .product      (product)
    );

endmodule

`default_nettype wire

/* bench/mul_checker.sv */
// Scoreboard for the multiplier testbench: predicts accepted requests and checks each product
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module mul_checker (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        start,
    input  mul_pkg::mul_req_t           req,
    input  logic [`MUL_PROD_WIDTH-1:0]  product,
    input  logic                        finished,
    output int                          errors,
    output int                          compared
);
    import mul_pkg::*;

    logic [`MUL_PROD_WIDTH-1:0] exp_q[$];
    int                         due_q[$];
    int                         edge_count = 0;
    int                         last_accept = 0;
    logic                       have_last = 1'b0;
    int                         err_count = 0;
    int                         cmp_count = 0;
    logic [`MUL_PROD_WIDTH-1:0] expected;
    int                         due;

    assign errors   = err_count;
    assign compared = cmp_count;

    // Extend each operand by its mode, then a plain 64-bit multiply
    function automatic logic [`MUL_PROD_WIDTH-1:0] ref_product(input mul_req_t r);
        logic [1:0]                 mode;
        logic [`MUL_PROD_WIDTH-1:0] a;
        logic [`MUL_PROD_WIDTH-1:0] b;
        mode = r.mode;
        a = mode[1] ? {{`MUL_WIDTH{r.multiplicand[`MUL_WIDTH-1]}}, r.multiplicand}
                    : {{`MUL_WIDTH{1'b0}}, r.multiplicand};
        b = mode[0] ? {{`MUL_WIDTH{r.multiplier[`MUL_WIDTH-1]}}, r.multiplier}
                    : {{`MUL_WIDTH{1'b0}}, r.multiplier};
        return a * b;
    endfunction

    always @(posedge CLK) begin
        if (!nRST) begin
            exp_q.delete();
            due_q.delete();
            have_last = 1'b0;
        end else begin
            edge_count = edge_count + 1;
            if (finished) begin
                if (exp_q.size() == 0) begin
                    $display("finished pulse at edge %0d with no request pending", edge_count);
                    err_count++;
                end else begin
                    expected = exp_q.pop_front();
                    due = due_q.pop_front();
                    cmp_count++;
                    if (due != edge_count) begin
                        $display("finished came at edge %0d instead of edge %0d", edge_count, due);
                        err_count++;
                    end
                    if (product !== expected) begin
                        $display("MISMATCH product: got %h expected %h", product, expected);
                        err_count++;
                    end
                end
            end else if (due_q.size() > 0 && due_q[0] <= edge_count) begin
                $display("missing finished pulse for the request due at edge %0d", due_q[0]);
                err_count++;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
            // Busy for MUL_LATENCY edges after an accepted start
            if (start && (!have_last || edge_count - last_accept > `MUL_LATENCY)) begin
                exp_q.push_back(ref_product(req));
                // finished rises at the last latency edge, seen here one edge later
                due_q.push_back(edge_count + `MUL_LATENCY + 1);
                last_accept = edge_count;
                have_last = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_pp_mul.sv */
// Testbench for the multiplier: corner, random, back-to-back, ignored-start, hold and reset tests
`timescale 1ns/10ps
`default_nettype none

`include "mul_defines.svh"

module tb_pp_mul;
    import mul_pkg::*;

    localparam int CORNER_OPS  = 100;
    localparam int RANDOM_OPS  = 400;
    localparam int B2B_OPS     = 24;
    localparam int EXTRA_OPS   = 6;
    localparam int OTHER_OPS   = 4;
    localparam int IDLE_CYCLES = 200;
    // Twice the expected run length
    localparam int MAX_CYCLES  = 2 * ((CORNER_OPS + RANDOM_OPS + B2B_OPS + EXTRA_OPS + OTHER_OPS)
                                      * (`MUL_LATENCY + 1) + IDLE_CYCLES);
    localparam int FINISH_WAIT = `MUL_LATENCY + 2;

    logic                       CLK;
    logic                       nRST;
    logic                       start;
    mul_req_t                   req;
    logic [`MUL_PROD_WIDTH-1:0] product;
    logic                       finished;
    int                         chk_errors;
    int                         chk_compared;
    int                         tb_errors;
    int                         seed;
    int                         cycles;
    int                         test_count;
    int                         errors_before;
    logic [`MUL_PROD_WIDTH-1:0] held;
    logic [`MUL_WIDTH-1:0]      corners [5];
    mul_req_t                   r;

    mul_pp_top i_dut (
        .CLK(CLK), .nRST(nRST), .start(start), .req(req), .product(product), .finished(finished)
    );

    mul_checker i_checker (
        .CLK(CLK), .nRST(nRST), .start(start), .req(req), .product(product),
        .finished(finished), .errors(chk_errors), .compared(chk_compared)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout after %0d cycles, run stopped", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    function automatic mul_req_t random_req();
        mul_req_t q;
        q.multiplicand = $random(seed);
        q.multiplier   = $random(seed);
        q.mode         = sign_mode_t'(2'($random(seed)));
        return q;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic run_op(input mul_req_t op);
        int waited;
        waited = 0;
        start = 1'b1;
        req = op;
        step();
        start = 1'b0;
        while (!finished && waited < FINISH_WAIT) begin
            step();
            waited++;
        end
        if (!finished) begin
            $display("no finished pulse within %0d cycles of start", FINISH_WAIT);
            tb_errors++;
        end
    endtask

    task automatic check_idle(input logic [`MUL_PROD_WIDTH-1:0] expected);
        if (finished) begin
            $display("finished pulse while no request is in flight");
            tb_errors++;
        end
        if (product !== expected) begin
            $display("MISMATCH product: got %h expected %h", product, expected);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) step();
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name,
                 tb_errors + chk_errors - errors_before);
        errors_before = tb_errors + chk_errors;
    endtask

    initial begin
        nRST = 1'b0;
        start = 1'b0;
        req = '0;
        seed = 32'hf401;
        tb_errors = 0;
        test_count = 0;
        errors_before = 0;
        corners = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        step();

        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    r.multiplicand = corners[i];
                    r.multiplier = corners[j];
                    r.mode = sign_mode_t'(2'(m));
                    run_op(r);
                end
            end
        end
        end_test("corner operands");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            run_op(random_req());
        end
        end_test("random operands");

        // A new start on every fourth edge, the earliest accepted
        for (int n = 0; n < B2B_OPS; n++) begin
            start = 1'b1;
            req = random_req();
            step();
            start = 1'b0;
            repeat (`MUL_LATENCY) step();
        end
        end_test("back-to-back");

        for (int n = 0; n < EXTRA_OPS; n++) begin
            start = 1'b1;
            req = random_req();
            step();
            // start stays high with new operands through E1 to E3
            repeat (`MUL_LATENCY) begin
                req = random_req();
                step();
            end
            start = 1'b0;
            step();
        end
        end_test("ignored starts");

        run_op(random_req());
        held = product;
        step();
        repeat (10) begin
            check_idle(held);
            step();
        end
        end_test("product hold");

        start = 1'b1;
        req = random_req();
        step();
        start = 1'b0;
        step();
        // Reset lands between E1 and E2
        nRST = 1'b0;
        #1;
        check_idle('0);
        repeat (2) step();
        nRST = 1'b1;
        repeat (6) begin
            check_idle('0);
            step();
        end
        run_op(random_req());
        end_test("reset mid-operation");

        $display("summary: %0d tests, %0d products compared, %0d errors",
                 test_count, chk_compared, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pp_mul.f */
+incdir+common
common/mul_pkg.sv
booth/carry_save_adder.sv
design/mul_control.sv
design/operand_prep.sv
booth/booth_encoder.sv
booth/wallace_tree.sv
design/product_adder.sv
design/pp_mul_top.sv
bench/mul_checker.sv
bench/tb_pp_mul.sv

/* run_sim.sh */
#!/bin/sh
# Builds the multiplier testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_pp_mul -f pp_mul.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_pp_mul)
echo "$out"
echo "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
